//--- design/clock_pkg.sv
// clock package: time field types, mode and link encodings, rollover limits
package clock_pkg;

    // --------------------
    // time fields
    // --------------------

    // binary hour, 0 to 23
    typedef logic [5:0] hour_t;

    // binary minute or second, 0 to 59
    typedef logic [5:0] min_sec_t;

    // two BCD digits, tens in the high nibble
    typedef logic [7:0] bcd2_t;

    // rollover limits
    localparam int HOURS_MAX   = 23;
    localparam int MIN_SEC_MAX = 59;

    // board clock cycles per second
    localparam int TICKS_PER_SEC_DEFAULT = 100000;

    // --------------------
    // state encodings
    // --------------------

    // raw selector value maps straight onto the mode
    typedef enum logic [1:0] {
        MODE_RUN      = 2'd0,
        MODE_SET_HOUR = 2'd1,
        MODE_SET_MIN  = 2'd2,
        MODE_HOLD     = 2'd3
    } clock_mode_e;

    // display link sender
    typedef enum logic [1:0] {
        LINK_IDLE    = 2'd0,
        LINK_REQ     = 2'd1,
        LINK_RELEASE = 2'd2
    } link_state_e;

endpackage

//--- design/clock_inputs.sv
// input conditioning: synchronizes the mode selector and turns button presses into pulses
`timescale 1ns/1ps

module clock_inputs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [1:0]             mode_sel,
    input  logic                   inc_btn,
    output clock_pkg::clock_mode_e mode,
    output logic                   inc_pulse
);

    import clock_pkg::*;

    // --------------------
    // synchronizers
    // --------------------

    // bit order is {mode_sel, inc_btn}
    logic [2:0] sync_meta;
    logic [2:0] sync_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            sync_meta <= {mode_sel, inc_btn};
            sync_q    <= sync_meta;
        end
    end

    // settled selector, reset value is MODE_RUN
    assign mode = clock_mode_e'(sync_q[2:1]);

    // --------------------
    // press detection
    // --------------------

    logic btn_level;
    logic btn_prev;

    assign btn_level = sync_q[0];

    // one pulse per rising edge, holding the button gives nothing more
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btn_prev  <= 1'b0;
            inc_pulse <= 1'b0;
        end else begin
            btn_prev  <= btn_level;
            inc_pulse <= btn_level & ~btn_prev;
        end
    end

endmodule

//--- design/second_timebase.sv
// second timebase: divides the system clock down to a one-cycle tick per second
`timescale 1ns/1ps

module second_timebase #(
    parameter int TICKS_PER_SEC = clock_pkg::TICKS_PER_SEC_DEFAULT
) (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic tick
);

    localparam int CNT_W = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;
    localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(TICKS_PER_SEC - 1);

    logic [CNT_W-1:0] count;
    logic             terminal;

    assign terminal = (count == LAST_COUNT);

    // cleared while stopped, so every run starts a full second
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (!run) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (terminal) begin
            count <= '0;
            tick  <= 1'b1;
        end else begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

//--- design/time_counter.sv
// time of day counter keeping hours, minutes and seconds with rollover and manual setting
`timescale 1ns/1ps

module time_counter (
    input  logic                   clk,
    input  logic                   rst,
    input  clock_pkg::clock_mode_e mode,
    input  logic                   inc_pulse,
    input  logic                   tick,
    output logic                   run,
    output clock_pkg::hour_t       hours,
    output clock_pkg::min_sec_t    minutes,
    output clock_pkg::min_sec_t    seconds,
    output logic                   time_changed
);

    import clock_pkg::*;

    // --------------------
    // next field values
    // --------------------

    logic     sec_last;
    logic     min_last;
    logic     hour_last;
    min_sec_t seconds_inc;
    min_sec_t minutes_inc;
    hour_t    hours_inc;

    assign sec_last  = (seconds == min_sec_t'(MIN_SEC_MAX));
    assign min_last  = (minutes == min_sec_t'(MIN_SEC_MAX));
    assign hour_last = (hours == hour_t'(HOURS_MAX));

    // each field wraps on its own limit
    assign seconds_inc = sec_last  ? '0 : seconds + min_sec_t'(1);
    assign minutes_inc = min_last  ? '0 : minutes + min_sec_t'(1);
    assign hours_inc   = hour_last ? '0 : hours + hour_t'(1);

    // --------------------
    // prescaler enable
    // --------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run <= 1'b0;
        end else begin
            run <= (mode == MODE_RUN);
        end
    end

    // --------------------
    // time registers
    // --------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hours        <= '0;
            minutes      <= '0;
            seconds      <= '0;
            time_changed <= 1'b0;
        end else begin
            time_changed <= 1'b0;
            case (mode)
                MODE_RUN: begin
                    if (tick) begin
                        seconds      <= seconds_inc;
                        time_changed <= 1'b1;
                        // carry chain seconds -> minutes -> hours
                        if (sec_last) begin
                            minutes <= minutes_inc;
                            if (min_last) begin
                                hours <= hours_inc;
                            end
                        end
                    end
                end
                MODE_SET_HOUR: begin
                    if (inc_pulse) begin
                        hours        <= hours_inc;
                        time_changed <= 1'b1;
                    end
                end
                MODE_SET_MIN: begin
                    // no carry into hours while setting
                    if (inc_pulse) begin
                        minutes      <= minutes_inc;
                        seconds      <= '0;
                        time_changed <= 1'b1;
                    end
                end
                MODE_HOLD: begin
                    // frozen time ignores ticks and presses
                end
            endcase
        end
    end

endmodule

//--- design/bcd_publisher.sv
// display publisher: converts the time to BCD and sends it over a four-phase req/ack link
`timescale 1ns/1ps

module bcd_publisher (
    input  logic                clk,
    input  logic                rst,
    input  clock_pkg::hour_t    hours,
    input  clock_pkg::min_sec_t minutes,
    input  clock_pkg::min_sec_t seconds,
    input  logic                time_changed,
    input  logic                disp_ack,
    output logic                disp_req,
    output clock_pkg::bcd2_t    disp_hours,
    output clock_pkg::bcd2_t    disp_minutes,
    output clock_pkg::bcd2_t    disp_seconds
);

    import clock_pkg::*;

    // tens digit by comparison, values never exceed 59
    function automatic bcd2_t to_bcd2(input logic [5:0] value);
        logic [3:0] tens;
        logic [5:0] rest;
        tens = 4'd0;
        rest = value;
        if (value >= 6'd50) begin
            tens = 4'd5;
            rest = value - 6'd50;
        end else if (value >= 6'd40) begin
            tens = 4'd4;
            rest = value - 6'd40;
        end else if (value >= 6'd30) begin
            tens = 4'd3;
            rest = value - 6'd30;
        end else if (value >= 6'd20) begin
            tens = 4'd2;
            rest = value - 6'd20;
        end else if (value >= 6'd10) begin
            tens = 4'd1;
            rest = value - 6'd10;
        end
        return {tens, rest[3:0]};
    endfunction

    bcd2_t cur_hours;
    bcd2_t cur_minutes;
    bcd2_t cur_seconds;

    assign cur_hours   = to_bcd2(hours);
    assign cur_minutes = to_bcd2(minutes);
    assign cur_seconds = to_bcd2(seconds);

    // --------------------
    // pending slot
    // --------------------

    link_state_e state;
    logic        pending;
    logic        load_now;
    bcd2_t       pend_hours;
    bcd2_t       pend_minutes;
    bcd2_t       pend_seconds;

    // a fresh change while idle bypasses the slot
    assign load_now = (state == LINK_IDLE) && !disp_ack && (time_changed || pending);

    always_ff @(posedge clk) begin
        if (time_changed) begin
            pend_hours   <= cur_hours;
            pend_minutes <= cur_minutes;
            pend_seconds <= cur_seconds;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (load_now) begin
            pending <= 1'b0;
        end else if (time_changed) begin
            pending <= 1'b1;
        end
    end

    // --------------------
    // link sender
    // --------------------

    assign disp_req = (state == LINK_REQ);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= LINK_IDLE;
            disp_hours   <= '0;
            disp_minutes <= '0;
            disp_seconds <= '0;
        end else begin
            case (state)
                LINK_IDLE: begin
                    if (load_now) begin
                        disp_hours   <= time_changed ? cur_hours : pend_hours;
                        disp_minutes <= time_changed ? cur_minutes : pend_minutes;
                        disp_seconds <= time_changed ? cur_seconds : pend_seconds;
                        state        <= LINK_REQ;
                    end
                end
                LINK_REQ: begin
                    if (disp_ack) begin
                        state <= LINK_RELEASE;
                    end
                end
                LINK_RELEASE: begin
                    // wait for the display to finish the cycle
                    if (!disp_ack) begin
                        state <= LINK_IDLE;
                    end
                end
                default: begin
                    state <= LINK_IDLE;
                end
            endcase
        end
    end

endmodule

//--- design/digital_clock_top.sv
// digital clock top: input conditioning, timekeeping and BCD display link
`timescale 1ns/1ps

module digital_clock_top #(
    parameter int TICKS_PER_SEC = clock_pkg::TICKS_PER_SEC_DEFAULT
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [1:0]       mode_sel,
    input  logic             inc_btn,
    input  logic             disp_ack,
    output logic             disp_req,
    output clock_pkg::bcd2_t disp_hours,
    output clock_pkg::bcd2_t disp_minutes,
    output clock_pkg::bcd2_t disp_seconds
);

    import clock_pkg::*;

    clock_mode_e mode;
    logic        inc_pulse;
    logic        run;
    logic        tick;
    hour_t       hours;
    min_sec_t    minutes;
    min_sec_t    seconds;
    logic        time_changed;

    // --------------------
    // input side
    // --------------------

    clock_inputs u_inputs (
        .clk       (clk),
        .rst       (rst),
        .mode_sel  (mode_sel),
        .inc_btn   (inc_btn),
        .mode      (mode),
        .inc_pulse (inc_pulse)
    );

    // --------------------
    // timekeeping
    // --------------------

    second_timebase #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) u_timebase (
        .clk  (clk),
        .rst  (rst),
        .run  (run),
        .tick (tick)
    );

    time_counter u_counter (
        .clk          (clk),
        .rst          (rst),
        .mode         (mode),
        .inc_pulse    (inc_pulse),
        .tick         (tick),
        .run          (run),
        .hours        (hours),
        .minutes      (minutes),
        .seconds      (seconds),
        .time_changed (time_changed)
    );

    // --------------------
    // display link
    // --------------------

    bcd_publisher u_publisher (
        .clk          (clk),
        .rst          (rst),
        .hours        (hours),
        .minutes      (minutes),
        .seconds      (seconds),
        .time_changed (time_changed),
        .disp_ack     (disp_ack),
        .disp_req     (disp_req),
        .disp_hours   (disp_hours),
        .disp_minutes (disp_minutes),
        .disp_seconds (disp_seconds)
    );

endmodule

//--- tb/digital_clock_asserts.sv
// display link checker: four-phase handshake rules and legal BCD digits
`timescale 1ns/1ps

module digital_clock_asserts (
    input logic                   clk,
    input logic                   rst,
    input clock_pkg::link_state_e state,
    input logic                   disp_ack,
    input logic                   disp_req,
    input clock_pkg::bcd2_t       disp_hours,
    input clock_pkg::bcd2_t       disp_minutes,
    input clock_pkg::bcd2_t       disp_seconds
);

    import clock_pkg::*;

    int fail_count = 0;

    function automatic bit bcd_legal(input bcd2_t value, input int limit);
        return (value[3:0] <= 4'd9) && (int'(value[7:4]) * 10 + int'(value[3:0]) <= limit);
    endfunction

    req_until_ack: assert property (@(posedge clk) disable iff (rst)
        disp_req && !disp_ack |=> disp_req)
    else begin
        fail_count = fail_count + 1;
        $error("disp_req dropped before disp_ack");
    end

    // data frozen for the whole request
    data_stable: assert property (@(posedge clk) disable iff (rst)
        disp_req |=> !disp_req || $stable({disp_hours, disp_minutes, disp_seconds}))
    else begin
        fail_count = fail_count + 1;
        $error("display data changed while disp_req high");
    end

    no_req_during_ack: assert property (@(posedge clk) disable iff (rst)
        !disp_req && disp_ack |=> state != LINK_REQ)
    else begin
        fail_count = fail_count + 1;
        $error("disp_req rose while disp_ack high");
    end

    digits_legal: assert property (@(posedge clk) disable iff (rst)
        disp_req |-> bcd_legal(disp_hours, HOURS_MAX) && bcd_legal(disp_minutes, MIN_SEC_MAX)
                     && bcd_legal(disp_seconds, MIN_SEC_MAX))
    else begin
        fail_count = fail_count + 1;
        $error("illegal BCD digits on the display link");
    end

endmodule

bind bcd_publisher digital_clock_asserts u_asserts (
    .clk          (clk),
    .rst          (rst),
    .state        (state),
    .disp_ack     (disp_ack),
    .disp_req     (disp_req),
    .disp_hours   (disp_hours),
    .disp_minutes (disp_minutes),
    .disp_seconds (disp_seconds)
);

//--- tb/digital_clock_tb.sv
// digital clock testbench checking random presses and ack stalls against a time model
`timescale 1ns/1ps

module digital_clock_tb;

    import clock_pkg::*;

    localparam int SEC_CYC     = 16;
    localparam int DAY_SECS    = 86400;
    localparam int STALLS      = 6;
    localparam int PRESS_CYC   = 24;
    localparam int PRESSES     = 23 + 59 + 2 * (30 + 70) + 5;
    localparam int RUN_SECS    = 65 + 1 + 6;
    localparam int TIMEOUT_CYC = (3 * (110 + PRESSES * PRESS_CYC + RUN_SECS * SEC_CYC
                                  + 200 + (STALLS + 2) * 100)) / 2;

    logic       clk = 1'b0;
    logic       rst;
    logic [1:0] mode_sel;
    logic       inc_btn;
    logic       disp_ack;
    logic       disp_req;
    bcd2_t      disp_hours;
    bcd2_t      disp_minutes;
    bcd2_t      disp_seconds;

    // last request seen by the display
    int pub_count = 0;
    int pub_cycle = 0;
    int pub_h = 0;
    int pub_m = 0;
    int pub_s = 0;
    int seen_count = 0;
    int prev_cycle = 0;
    int cycle_count = 0;
    bit stall_acks = 1'b0;

    // reference time
    int mh = 0;
    int mm = 0;
    int ms = 0;

    digital_clock_top #(.TICKS_PER_SEC(SEC_CYC)) UUT (
        .clk          (clk),
        .rst          (rst),
        .mode_sel     (mode_sel),
        .inc_btn      (inc_btn),
        .disp_ack     (disp_ack),
        .disp_req     (disp_req),
        .disp_hours   (disp_hours),
        .disp_minutes (disp_minutes),
        .disp_seconds (disp_seconds)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYC) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    // --------------------
    // display responder
    // --------------------
    initial begin
        int delay;
        disp_ack <= 1'b0;
        forever begin
            @(posedge clk);
            if (disp_req) begin
                pub_h = int'(disp_hours);
                pub_m = int'(disp_minutes);
                pub_s = int'(disp_seconds);
                pub_cycle = cycle_count;
                pub_count = pub_count + 1;
                delay = stall_acks ? 40 + int'($urandom % 41) : 1 + int'($urandom % 4);
                repeat (delay - 1) @(posedge clk);
                disp_ack <= 1'b1;
                @(posedge clk);
                while (disp_req) @(posedge clk);
                disp_ack <= 1'b0;
            end
        end
    end

    // --------------------
    // model and checks
    // --------------------
    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERROR %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic int to_bcd(input int value);
        return (value / 10) * 16 + value % 10;
    endfunction

    function automatic int bcd_seconds(input int h, input int m, input int s);
        return ((h / 16) * 10 + h % 16) * 3600 + ((m / 16) * 10 + m % 16) * 60
               + (s / 16) * 10 + s % 16;
    endfunction

    task automatic advance_second();
        ms = ms + 1;
        if (ms == 60) begin
            ms = 0;
            mm = (mm + 1) % 60;
            if (mm == 0) begin
                mh = (mh + 1) % 24;
            end
        end
    endtask

    task automatic wait_publish();
        prev_cycle = pub_cycle;
        while (pub_count == seen_count) @(posedge clk);
        seen_count = pub_count;
    endtask

    task automatic check_published();
        check_value("disp_hours", to_bcd(mh), pub_h);
        check_value("disp_minutes", to_bcd(mm), pub_m);
        check_value("disp_seconds", to_bcd(ms), pub_s);
    endtask

    task automatic expect_next_second();
        wait_publish();
        advance_second();
        check_published();
    endtask

    // step after a stall is the elapsed time within one second
    task automatic expect_late_update();
        int est;
        int step;
        wait_publish();
        est = (pub_cycle - prev_cycle) / SEC_CYC;
        step = bcd_seconds(pub_h, pub_m, pub_s) - (mh * 3600 + mm * 60 + ms);
        step = (step + DAY_SECS) % DAY_SECS;
        check_value("elapsed seconds", est,
                    (step >= est - 1 && step <= est + 1) ? est : step);
        repeat (step) advance_second();
        check_published();
    endtask

    task automatic pulse_button();
        inc_btn <= 1'b1;
        repeat (1 + int'($urandom % 4)) @(posedge clk);
        inc_btn <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic press_and_check(input bit minute);
        pulse_button();
        if (minute) begin
            mm = (mm + 1) % 60;
            ms = 0;
        end else begin
            mh = (mh + 1) % 24;
        end
        wait_publish();
        check_published();
    endtask

    task automatic change_mode(input clock_mode_e m);
        mode_sel <= m;
        repeat (4) @(posedge clk);
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        int presses;
        void'($urandom(2));
        rst      <= 1'b1;
        mode_sel <= MODE_HOLD;
        inc_btn  <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (100) @(posedge clk);
        check_value("disp_req", 0, int'(disp_req));
        check_value("publication count", 0, pub_count);

        // start at 23:59 so the run crosses midnight
        change_mode(MODE_SET_HOUR);
        repeat (23) press_and_check(1'b0);
        change_mode(MODE_SET_MIN);
        repeat (59) press_and_check(1'b1);
        change_mode(MODE_RUN);
        repeat (65) expect_next_second();

        repeat (2) begin
            change_mode(MODE_SET_HOUR);
            presses = 1 + int'($urandom % 30);
            repeat (presses) press_and_check(1'b0);
            change_mode(MODE_SET_MIN);
            presses = 1 + int'($urandom % 70);
            repeat (presses) press_and_check(1'b1);
        end

        // frozen time ignores presses
        change_mode(MODE_HOLD);
        repeat (5) pulse_button();
        repeat (200) @(posedge clk);
        check_value("publication count", seen_count, pub_count);
        change_mode(MODE_RUN);
        expect_next_second();

        stall_acks = 1'b1;
        expect_next_second();
        repeat (STALLS) expect_late_update();
        stall_acks = 1'b0;
        expect_late_update();
        repeat (5) expect_next_second();

        if (UUT.u_publisher.u_asserts.fail_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("display link assertions failed %0d times",
                     UUT.u_publisher.u_asserts.fail_count);
            $display("Testbench failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

//--- digital_clock_top.f
design/clock_pkg.sv
design/clock_inputs.sv
design/second_timebase.sv
design/time_counter.sv
design/bcd_publisher.sv
design/digital_clock_top.sv
tb/digital_clock_asserts.sv
tb/digital_clock_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the digital clock testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -f digital_clock_top.f \
        --top-module digital_clock_tb --Mdir obj_dir -o digital_clock_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/digital_clock_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
    echo "simulation run ok"
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
